//--- Makefile
# Verilator build and run of the playback control testbench

TOP := tb_audio_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/audio_ctrl_testdata.txt
# Columns: tag and hex byte. I input byte, S expected sink byte,
# R expected reply byte, C expected cfg_o, X reset with the value ignored
I 01
I B1
C 71
I 41
I 3C
I 01
I EE
C AE
I 84
I 12
I 34
I 56
I 78
S 12
S 34
S 56
S 78
I C0
R C1
R 00
I 01
I 05
C 45
X 00
I C1
R C1
R 02
I 11
I 22
I 33
X 00
I 02
R C1
R 01
I 5A
I 5B

//--- sim/tb_audio_ctrl.sv
/* Testbench for the playback control path with FIFO and sink models,
   file-driven stimulus, checks and a watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_audio_ctrl;

    logic                     clk;
    logic                     reset_i;
    logic                     in_rd_en_o;
    logic                     in_empty_i;
    logic [7:0]               in_data_i;
    logic                     out_wr_en_o;
    logic [7:0]               out_data_o;
    logic                     out_full_i;
    logic                     out_afull_i;
    logic                     sink_wr_en_o;
    logic [7:0]               sink_data_o;
    logic                     sink_full_i;
    logic                     streaming_i;
    audio_ctrl_pkg::out_cfg_t cfg_o;
    logic                     err_led_o;

    // Test data entries, one tag and one value each
    logic [7:0] ent_tag[$];
    logic [7:0] ent_val[$];
    // Input FIFO contents and expected outputs of the current segment
    logic [7:0] in_q[$];
    logic [7:0] exp_sink[$];
    logic [7:0] exp_reply[$];
    logic [7:0] exp_cfg[$];

    int          errors = 0;
    int          checks = 0;
    int          wd_cycles = 0;
    logic [31:0] rng = 32'h27960acf;
    // Model state
    logic        rd_seen;
    logic [7:0]  rd_data;
    logic        out_busy_prev;
    logic        reply_idx;
    logic [7:0]  cfg_prev;
    logic [7:0]  cfg_model;
    int          play_cnt;
    int          drain_cnt;

    audio_ctrl #(
        .SYNC_STAGES (2)
    ) dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .in_rd_en_o   (in_rd_en_o),
        .in_empty_i   (in_empty_i),
        .in_data_i    (in_data_i),
        .out_wr_en_o  (out_wr_en_o),
        .out_data_o   (out_data_o),
        .out_full_i   (out_full_i),
        .out_afull_i  (out_afull_i),
        .sink_wr_en_o (sink_wr_en_o),
        .sink_data_o  (sink_data_o),
        .sink_full_i  (sink_full_i),
        .streaming_i  (streaming_i),
        .cfg_o        (cfg_o),
        .err_led_o    (err_led_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic compare_byte(input string name, input logic [7:0] expv,
                                input logic [7:0] actv);
        checks++;
        assert (actv === expv)
        else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expv, actv);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // ========================================================================
    // Models and cycle stepping
    // ========================================================================

    // Outputs are stable at the falling edge
    task automatic sample_outputs();
        logic [7:0] cfg_now;
        cfg_now = cfg_o;
        rd_seen = in_rd_en_o;
        if (err_led_o) begin
            require(!in_rd_en_o, "input FIFO read while halted after an error");
        end
        if (in_rd_en_o) begin
            require(in_q.size() != 0, "input FIFO read while empty");
            if (in_q.size() != 0) begin
                rd_data = in_q.pop_front();
            end
        end
        if (sink_wr_en_o) begin
            play_cnt++;
            if (exp_sink.size() == 0) begin
                require(1'b0, $sformatf("unexpected sink write of %h", sink_data_o));
            end else begin
                compare_byte("sink byte", exp_sink.pop_front(), sink_data_o);
            end
        end
        if (out_wr_en_o) begin
            // Flags as seen by the DUT at the edge that started this write
            require(!out_busy_prev, "reply byte written while output FIFO was full");
            if (exp_reply.size() == 0) begin
                require(1'b0, $sformatf("unexpected reply byte %h", out_data_o));
            end else begin
                compare_byte("reply byte", exp_reply.pop_front(), out_data_o);
            end
            if (reply_idx && out_data_o == 8'h00) begin
                require(!streaming_i, "stopped reply sent while streaming_i was high");
            end else if (reply_idx) begin
                require(err_led_o, "error reply sent with err_led_o low");
            end
            reply_idx = !reply_idx;
        end
        if (cfg_now != cfg_prev) begin
            if (exp_cfg.size() == 0) begin
                require(1'b0, $sformatf("cfg_o changed to %h with no setup due", cfg_now));
            end else begin
                cfg_model = exp_cfg.pop_front();
                compare_byte("cfg_o", cfg_model, cfg_now);
            end
            cfg_prev = cfg_now;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic drive_inputs();
        out_busy_prev = out_full_i || out_afull_i;
        rng = xorshift(rng);
        // Read data one cycle after rd_en
        if (rd_seen) begin
            in_data_i = rd_data;
        end
        in_empty_i  = (in_q.size() == 0);
        out_afull_i = (rng[2:0] < 3'd3);
        out_full_i  = (rng[5:3] == 3'd0);
        sink_full_i = (rng[7:6] == 2'd0);
        // Playback of buffered samples, then a drain tail
        if (play_cnt != 0) begin
            if (rng[8]) begin
                play_cnt--;
                if (play_cnt == 0) begin
                    drain_cnt = 2 + rng[12:9];
                end
            end
        end else if (drain_cnt != 0) begin
            drain_cnt--;
        end
        streaming_i = (play_cnt != 0) || (drain_cnt != 0);
    endtask

    task automatic step_cycle();
        @(negedge clk);
        sample_outputs();
        @(posedge clk);
        #1;
        drive_inputs();
    endtask

    // Input FIFO and sink are reset with the DUT
    task automatic apply_reset();
        reset_i       = 1'b1;
        in_q.delete();
        in_empty_i    = 1'b1;
        in_data_i     = 8'h00;
        out_full_i    = 1'b0;
        out_afull_i   = 1'b0;
        sink_full_i   = 1'b0;
        streaming_i   = 1'b0;
        rd_seen       = 1'b0;
        rd_data       = 8'h00;
        out_busy_prev = 1'b0;
        reply_idx     = 1'b0;
        cfg_prev      = 8'h00;
        cfg_model     = 8'h00;
        play_cnt      = 0;
        drain_cnt     = 0;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;
    endtask

    // Run until all expected outputs are seen, then let things settle
    task automatic run_segment();
        while (exp_sink.size() != 0 || exp_reply.size() != 0 || exp_cfg.size() != 0 ||
               (in_q.size() != 0 && !err_led_o)) begin
            step_cycle();
        end
        repeat (30) step_cycle();
        compare_byte("final cfg_o", cfg_model, cfg_o);
        if (err_led_o) begin
            require(in_q.size() != 0, "no input was pending while halted");
        end
    endtask

    task automatic load_testdata();
        int         fd;
        int         n;
        string      line;
        string      tag;
        logic [7:0] val;
        logic [7:0] c;
        fd = $fopen("sim/audio_ctrl_testdata.txt", "r");
        require(fd != 0, "cannot open sim/audio_ctrl_testdata.txt");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h", tag, val);
                if (n == 2 && tag != "#") begin
                    c = tag.getc(0);
                    require(c inside {"I", "S", "R", "C", "X"},
                            $sformatf("unknown test data tag %s", tag));
                    ent_tag.push_back(c);
                    ent_val.push_back(val);
                    if (c == "I") begin
                        wd_cycles += 400;
                    end
                end
            end
            $fclose(fd);
        end
        require(ent_tag.size() != 0, "test data holds no entries");
        wd_cycles += 400;
    endtask

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial begin
        int i;
        load_testdata();
        apply_reset();
        for (i = 0; i < ent_tag.size(); i++) begin
            case (ent_tag[i])
                "I": in_q.push_back(ent_val[i]);
                "S": exp_sink.push_back(ent_val[i]);
                "R": exp_reply.push_back(ent_val[i]);
                "C": exp_cfg.push_back(ent_val[i]);
                "X": begin
                    run_segment();
                    apply_reset();
                end
                default: ;
            endcase
        end
        run_segment();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", wd_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/audio_ctrl_pkg.sv
verilog/reply_if.sv
verilog/host_reader.sv
verilog/cmd_parser.sv
verilog/stop_sequencer.sv
verilog/reply_arbiter.sv
verilog/audio_ctrl.sv
sim/tb_audio_ctrl.sv

//--- verilog/audio_ctrl.sv
/* Playback control top level with host FIFOs, sample sink and configuration */
`timescale 1ns/1ps
`default_nettype none

module audio_ctrl #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                     clk,
    input  logic                     reset_i,
    // Input FIFO from the host
    output logic                     in_rd_en_o,
    input  logic                     in_empty_i,
    input  logic [7:0]               in_data_i,
    // Output FIFO to the host
    output logic                     out_wr_en_o,
    output logic [7:0]               out_data_o,
    input  logic                     out_full_i,
    input  logic                     out_afull_i,
    // Audio transmitter sink
    output logic                     sink_wr_en_o,
    output logic [7:0]               sink_data_o,
    input  logic                     sink_full_i,
    input  logic                     streaming_i,
    // Configuration and status
    output audio_ctrl_pkg::out_cfg_t cfg_o,
    output logic                     err_led_o
);

    logic                     take;
    logic                     byte_valid;
    audio_ctrl_pkg::in_byte_u byte_data;
    logic                     stop_req;
    logic                     stop_busy;

    // Reply requests from the two peers
    reply_if err_rep ();
    reply_if stop_rep ();

    host_reader u_host_reader (
        .clk          (clk),
        .reset_i      (reset_i),
        .in_rd_en_o   (in_rd_en_o),
        .in_empty_i   (in_empty_i),
        .in_data_i    (in_data_i),
        .take_i       (take),
        .byte_valid_o (byte_valid),
        .byte_data_o  (byte_data)
    );

    cmd_parser u_cmd_parser (
        .clk          (clk),
        .reset_i      (reset_i),
        .byte_valid_i (byte_valid),
        .byte_data_i  (byte_data),
        .take_o       (take),
        .sink_wr_en_o (sink_wr_en_o),
        .sink_data_o  (sink_data_o),
        .sink_full_i  (sink_full_i),
        .cfg_o        (cfg_o),
        .stop_req_o   (stop_req),
        .stop_busy_i  (stop_busy),
        .err_led_o    (err_led_o),
        .err          (err_rep.requester)
    );

    stop_sequencer #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_stop_sequencer (
        .clk         (clk),
        .reset_i     (reset_i),
        .stop_req_i  (stop_req),
        .streaming_i (streaming_i),
        .stop_busy_o (stop_busy),
        .rep         (stop_rep.requester)
    );

    reply_arbiter u_reply_arbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .err_rep     (err_rep.arbiter),
        .stop_rep    (stop_rep.arbiter),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o),
        .out_full_i  (out_full_i),
        .out_afull_i (out_afull_i)
    );

endmodule

`default_nettype wire

//--- verilog/audio_ctrl_pkg.sv
/* Command, reply, configuration and error types and constants
   shared by the playback control path */
`default_nettype none

package audio_ctrl_pkg;

    // ========================================================================
    // Host command header
    // ========================================================================

    // Two-bit command code in the header
    typedef enum logic [1:0] {
        CMD_SETUP_OUTPUT  = 2'd0,
        CMD_SETUP_INPUT   = 2'd1,
        CMD_STREAM_OUTPUT = 2'd2,
        CMD_STOP          = 2'd3
    } cmd_e;

    // Output type field of the setup payload
    typedef enum logic [1:0] {
        IO_AES3    = 2'd0,
        IO_BNC     = 2'd1,
        IO_TOSLINK = 2'd2,
        IO_I2S     = 2'd3
    } io_type_e;

    // One host byte, read as a header or as a setup payload
    typedef union packed {
        struct packed {
            cmd_e       cmd;
            logic [5:0] len;
        } hdr;
        struct packed {
            io_type_e   io_type;
            logic       channels;
            logic [2:0] sample_rate;
            logic [1:0] bit_depth;
        } setup;
    } in_byte_u;

    // ========================================================================
    // Output configuration and replies
    // ========================================================================

    // Index into io_en
    localparam int IO_SPDIF_BIT = 0;
    localparam int IO_I2S_BIT   = 1;

    // Configuration seen by the transmitters
    typedef struct packed {
        logic [1:0] io_en;
        logic       channels;
        logic [2:0] sample_rate;
        logic [1:0] bit_depth;
    } out_cfg_t;

    // Second reply byte
    typedef enum logic [7:0] {
        ERR_NONE                  = 8'd0,
        ERR_INVALID_SETUP_PAYLOAD = 8'd1,
        ERR_INVALID_STOP_PAYLOAD  = 8'd2
    } err_code_e;

    // Stop command with one payload byte
    localparam logic [7:0] REPLY_HEADER = 8'hC1;

endpackage

`default_nettype wire

//--- verilog/cmd_parser.sv
/* Command header and payload parser with output configuration,
   sample forwarding and payload length error detection */
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
    input  logic                     clk,
    input  logic                     reset_i,
    // Host bytes
    input  logic                     byte_valid_i,
    input  audio_ctrl_pkg::in_byte_u byte_data_i,
    output logic                     take_o,
    // Sample sink
    output logic                     sink_wr_en_o,
    output logic [7:0]               sink_data_o,
    input  logic                     sink_full_i,
    // Configuration
    output audio_ctrl_pkg::out_cfg_t cfg_o,
    // Stop sequencer
    output logic                     stop_req_o,
    input  logic                     stop_busy_i,
    // Error path
    output logic                     err_led_o,
    reply_if.requester               err
);

    localparam logic ST_HEADER  = 1'b0;
    localparam logic ST_PAYLOAD = 1'b1;

    logic                      state;
    logic [5:0]                rem_len;
    audio_ctrl_pkg::cmd_e      last_cmd;
    logic                      err_req_q;
    audio_ctrl_pkg::err_code_e err_code_q;
    logic                      consume;

    assign err.req  = err_req_q;
    assign err.code = err_code_q;

    // Halted after an error, paused during a stop, or sink full while streaming
    assign take_o = !err_led_o && !stop_busy_i &&
                    !(state == ST_PAYLOAD &&
                      last_cmd == audio_ctrl_pkg::CMD_STREAM_OUTPUT && sink_full_i);
    assign consume = byte_valid_i && take_o;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state        <= ST_HEADER;
            rem_len      <= 6'd0;
            last_cmd     <= audio_ctrl_pkg::CMD_SETUP_OUTPUT;
            err_req_q    <= 1'b0;
            err_code_q   <= audio_ctrl_pkg::ERR_NONE;
            err_led_o    <= 1'b0;
            stop_req_o   <= 1'b0;
            sink_wr_en_o <= 1'b0;
            cfg_o        <= '0;
        end else begin
            stop_req_o   <= 1'b0;
            sink_wr_en_o <= 1'b0;
            // Request stays up until the arbiter has sent it
            if (err.done) begin
                err_req_q <= 1'b0;
            end

            if (consume && state == ST_HEADER) begin
                last_cmd <= byte_data_i.hdr.cmd;
                rem_len  <= byte_data_i.hdr.len;
                case (byte_data_i.hdr.cmd)
                    audio_ctrl_pkg::CMD_SETUP_OUTPUT: begin
                        if (byte_data_i.hdr.len == 6'd1) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            err_req_q  <= 1'b1;
                            err_code_q <= audio_ctrl_pkg::ERR_INVALID_SETUP_PAYLOAD;
                            err_led_o  <= 1'b1;
                        end
                    end
                    audio_ctrl_pkg::CMD_STOP: begin
                        if (byte_data_i.hdr.len == 6'd0) begin
                            stop_req_o <= 1'b1;
                        end else begin
                            err_req_q  <= 1'b1;
                            err_code_q <= audio_ctrl_pkg::ERR_INVALID_STOP_PAYLOAD;
                            err_led_o  <= 1'b1;
                        end
                    end
                    // Setup input and stream output carry any length
                    default: begin
                        if (byte_data_i.hdr.len != 6'd0) begin
                            state <= ST_PAYLOAD;
                        end
                    end
                endcase
            end else if (consume) begin
                rem_len <= rem_len - 6'd1;
                if (rem_len == 6'd1) begin
                    state <= ST_HEADER;
                end
                if (last_cmd == audio_ctrl_pkg::CMD_STREAM_OUTPUT) begin
                    sink_wr_en_o <= 1'b1;
                end
                if (last_cmd == audio_ctrl_pkg::CMD_SETUP_OUTPUT) begin
                    // The three SPDIF flavours share one transmitter
                    case (byte_data_i.setup.io_type)
                        audio_ctrl_pkg::IO_AES3,
                        audio_ctrl_pkg::IO_BNC,
                        audio_ctrl_pkg::IO_TOSLINK: begin
                            cfg_o.io_en <= 2'b01 << audio_ctrl_pkg::IO_SPDIF_BIT;
                        end
                        default: begin
                            cfg_o.io_en <= 2'b01 << audio_ctrl_pkg::IO_I2S_BIT;
                        end
                    endcase
                    cfg_o.channels    <= byte_data_i.setup.channels;
                    cfg_o.sample_rate <= byte_data_i.setup.sample_rate;
                    cfg_o.bit_depth   <= byte_data_i.setup.bit_depth;
                end
            end
        end
    end

    // Sample data
    always_ff @(posedge clk) begin
        if (consume && state == ST_PAYLOAD) begin
            sink_data_o <= byte_data_i;
        end
    end

    // Sink full is sampled when the byte is taken, one cycle before the write
    assert property (@(posedge clk) disable iff (reset_i)
        sink_wr_en_o |-> !$past(sink_full_i))
        else $error("cmd_parser: sink written after full");

endmodule

`default_nettype wire

//--- verilog/host_reader.sv
/* Input FIFO reader with read latency tracking and a one-byte hold register */
`timescale 1ns/1ps
`default_nettype none

module host_reader (
    input  logic                     clk,
    input  logic                     reset_i,
    // Input FIFO
    output logic                     in_rd_en_o,
    input  logic                     in_empty_i,
    input  logic [7:0]               in_data_i,
    // Parser side
    input  logic                     take_i,
    output logic                     byte_valid_o,
    output audio_ctrl_pkg::in_byte_u byte_data_o
);

    // Read issued last cycle, data on in_data_i now
    logic       rd_pending;
    // Byte that arrived while the parser could not take it
    logic       held;
    logic [7:0] hold_q;

    // No new read while a byte waits in the hold register
    assign in_rd_en_o = !in_empty_i && take_i && !held;

    // Held byte goes first, otherwise the fresh FIFO output
    assign byte_valid_o = held || rd_pending;
    assign byte_data_o  = held ? hold_q : in_data_i;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            rd_pending <= 1'b0;
            held       <= 1'b0;
        end else begin
            rd_pending <= in_rd_en_o;
            if (rd_pending && !take_i) begin
                // Parser stalled in the data cycle
                held <= 1'b1;
            end else if (held && take_i) begin
                held <= 1'b0;
            end
        end
    end

    // Hold data
    always_ff @(posedge clk) begin
        if (rd_pending && !take_i) begin
            hold_q <= in_data_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reply_arbiter.sv
/* Fixed-priority reply arbiter and two-byte output FIFO writer */
`timescale 1ns/1ps
`default_nettype none

module reply_arbiter (
    input  logic       clk,
    input  logic       reset_i,
    reply_if.arbiter   err_rep,
    reply_if.arbiter   stop_rep,
    // Output FIFO
    output logic       out_wr_en_o,
    output logic [7:0] out_data_o,
    input  logic       out_full_i,
    input  logic       out_afull_i
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SEND  = 2'd1;
    localparam logic [1:0] ST_FLUSH = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic                      [1:0] state;
    logic                      sel_err;
    logic                      byte_idx;
    logic                      fifo_ready;
    audio_ctrl_pkg::err_code_e sel_code;

    assign fifo_ready = !out_full_i && !out_afull_i;

    // Error reply wins
    assign err_rep.grant  = (state == ST_IDLE) && err_rep.req;
    assign stop_rep.grant = (state == ST_IDLE) && stop_rep.req && !err_rep.req;

    // Done one cycle after the second byte is on the FIFO port
    assign err_rep.done  = (state == ST_DONE) && sel_err;
    assign stop_rep.done = (state == ST_DONE) && !sel_err;

    // Requester holds its code until done
    assign sel_code = sel_err ? err_rep.code : stop_rep.code;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state       <= ST_IDLE;
            sel_err     <= 1'b0;
            byte_idx    <= 1'b0;
            out_wr_en_o <= 1'b0;
        end else begin
            out_wr_en_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (err_rep.grant || stop_rep.grant) begin
                        sel_err  <= err_rep.grant;
                        byte_idx <= 1'b0;
                        state    <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    // Wait while the host FIFO is full or nearly full
                    if (fifo_ready) begin
                        out_wr_en_o <= 1'b1;
                        byte_idx    <= 1'b1;
                        if (byte_idx) begin
                            state <= ST_FLUSH;
                        end
                    end
                end
                ST_FLUSH: begin
                    state <= ST_DONE;
                end
                default: begin
                    // Requester drops req in this cycle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Reply bytes, header first
    always_ff @(posedge clk) begin
        if (state == ST_SEND && fifo_ready) begin
            out_data_o <= byte_idx ? 8'(sel_code) : audio_ctrl_pkg::REPLY_HEADER;
        end
    end

    // Granted requester keeps its request up until done
    assert property (@(posedge clk) disable iff (reset_i)
        (state != ST_IDLE) |-> (sel_err ? err_rep.req : stop_rep.req))
        else $error("reply_arbiter: request dropped before done");

endmodule

`default_nettype wire

//--- verilog/reply_if.sv
/* Reply request link between one requester and the reply arbiter */
`timescale 1ns/1ps
`default_nettype none

interface reply_if;

    // Held by the requester until done
    logic                      req;
    audio_ctrl_pkg::err_code_e code;
    // One-cycle pulses from the arbiter
    logic                      grant;
    logic                      done;

    modport requester (
        output req,
        output code,
        input  grant,
        input  done
    );

    modport arbiter (
        input  req,
        input  code,
        output grant,
        output done
    );

endinterface

`default_nettype wire

//--- verilog/stop_sequencer.sv
/* Streaming level synchronizer and stopped reply requester */
`timescale 1ns/1ps
`default_nettype none

module stop_sequencer #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stop_req_i,
    input  logic       streaming_i,
    output logic       stop_busy_o,
    reply_if.requester rep
);

    localparam int CNT_W = $clog2(SYNC_STAGES + 2);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_WAIT_END = 2'd1;
    localparam logic [1:0] ST_REQUEST  = 2'd2;

    logic [1:0]             state;
    logic [SYNC_STAGES-1:0] stream_sync;
    logic [CNT_W-1:0]       settle_cnt;

    assign rep.req     = (state == ST_REQUEST);
    assign rep.code    = audio_ctrl_pkg::ERR_NONE;
    // Busy from the request pulse itself so no byte slips past the stop
    assign stop_busy_o = (state != ST_IDLE) || stop_req_i;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state       <= ST_IDLE;
            stream_sync <= '0;
            settle_cnt  <= '0;
        end else begin
            stream_sync <= (stream_sync << 1) | SYNC_STAGES'(streaming_i);
            case (state)
                ST_IDLE: begin
                    if (stop_req_i) begin
                        // Let the last sink write reach the synchronizer output
                        settle_cnt <= CNT_W'(SYNC_STAGES + 1);
                        state      <= ST_WAIT_END;
                    end
                end
                ST_WAIT_END: begin
                    if (settle_cnt != '0) begin
                        settle_cnt <= settle_cnt - 1'b1;
                    end else if (!stream_sync[SYNC_STAGES-1]) begin
                        state <= ST_REQUEST;
                    end
                end
                default: begin
                    if (rep.done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Parser must stay paused for the whole stop sequence
    assert property (@(posedge clk) disable iff (reset_i)
        stop_req_i |-> state == ST_IDLE)
        else $error("stop_sequencer: stop request during a stop sequence");

endmodule

`default_nettype wire
